/* sources.f */
+incdir+include
source/slink_pkg.sv
source/slink_serializer.sv
source/slink_deserializer.sv
source/slink_dram_model.sv
source/slink_top.sv
sim/slink_tb.sv

/* Makefile */
# Verilator flow for the serial memory link testbench

TOP := slink_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f sources.f --top-module $(TOP)

obj_dir/V$(TOP): sources.f $(wildcard source/*.sv include/*.svh sim/*.sv)
	verilator --binary --timing --assert -f sources.f --top-module $(TOP) -o V$(TOP)

# Pass only if the run printed the pass line
sim: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "No errors"

clean:
	rm -rf obj_dir

/* sim/slink_tb.sv */
// Testbench for the serial memory link loop.
// Reads only touch addresses written earlier, since the memory model starts as X.
// Expected responses come from a reference array indexed by the low address bits.

`timescale 1ns/100ps

`include "slink_defs.svh"

module slink_tb import slink_pkg::*; ();

  localparam int NUM_TESTS    = 24;
  localparam int RESET_CYCLES = 16;
  localparam int TIMEOUT_NS   = NUM_TESTS * 60 * 20;
  localparam int LONG_STALL   = 30;
  localparam int STALL_NONE   = 0;
  localparam int STALL_RAND   = 1;
  localparam int STALL_LONG   = 2;

  logic     clk_i;
  logic     rst_i;
  mem_req_t req_i;
  logic     req_valid_i;
  logic     req_ready_o;
  mem_rsp_t rsp_o;
  logic     rsp_valid_o;
  logic     rsp_ready_i;

  // Stimulus table
  string                    t_name  [NUM_TESTS];
  mem_op_e                  t_op    [NUM_TESTS];
  logic [`SLINK_ADDR_W-1:0] t_addr  [NUM_TESTS];
  logic [`SLINK_DATA_W-1:0] t_wdata [NUM_TESTS];
  logic                     t_rand  [NUM_TESTS];
  int                       t_stall [NUM_TESTS];
  int                       t_gap   [NUM_TESTS];
  int                       n_entries;

  // Reference model state
  logic [`SLINK_DATA_W-1:0] ref_mem [`SLINK_MEM_WORDS];
  mem_rsp_t                 exp_q[$];
  int                       idx_q[$];

  int seed;
  int errors;
  int checks;
  int stall_cnt;

  slink_top u_dut (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .req_i       (req_i),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .rsp_o       (rsp_o),
    .rsp_valid_o (rsp_valid_o),
    .rsp_ready_i (rsp_ready_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  //////////////////////////////
  // Table and helpers
  //////////////////////////////

  task automatic add_entry(input string name, input mem_op_e op,
                           input logic [`SLINK_ADDR_W-1:0] addr,
                           input logic [`SLINK_DATA_W-1:0] wdata,
                           input logic rnd, input int stall, input int gap);
    t_name[n_entries]  = name;
    t_op[n_entries]    = op;
    t_addr[n_entries]  = addr;
    t_wdata[n_entries] = wdata;
    t_rand[n_entries]  = rnd;
    t_stall[n_entries] = stall;
    t_gap[n_entries]   = gap;
    n_entries++;
  endtask

  task automatic fill_table();
    n_entries = 0;
    add_entry("wr_a",        MEM_WRITE, 16'h0010, 32'h1122_3344, 1'b0, STALL_NONE, 2);
    add_entry("wr_b",        MEM_WRITE, 16'h0020, 32'hA5A5_5A5A, 1'b0, STALL_NONE, 2);
    add_entry("rd_a",        MEM_READ,  16'h0010, 32'h0,         1'b0, STALL_NONE, 2);
    add_entry("rd_b",        MEM_READ,  16'h0020, 32'h0,         1'b0, STALL_NONE, 2);
    add_entry("wr_alias",    MEM_WRITE, 16'h0012, 32'hCAFE_F00D, 1'b0, STALL_NONE, 1);
    add_entry("rd_alias",    MEM_READ,  16'h0112, 32'h0,         1'b0, STALL_NONE, 1);
    add_entry("wr_alias_hi", MEM_WRITE, 16'hFF34, 32'h0BAD_BEEF, 1'b0, STALL_NONE, 1);
    add_entry("rd_alias_lo", MEM_READ,  16'h0034, 32'h0,         1'b0, STALL_NONE, 1);
    // Back-to-back burst
    add_entry("burst_wr0",   MEM_WRITE, 16'h0040, 32'h0,         1'b1, STALL_NONE, 0);
    add_entry("burst_wr1",   MEM_WRITE, 16'h0041, 32'h0,         1'b1, STALL_NONE, 0);
    add_entry("burst_wr2",   MEM_WRITE, 16'h0042, 32'h0,         1'b1, STALL_NONE, 0);
    add_entry("burst_rd1",   MEM_READ,  16'h0041, 32'h0,         1'b0, STALL_NONE, 0);
    add_entry("burst_rd0",   MEM_READ,  16'h0040, 32'h0,         1'b0, STALL_NONE, 0);
    add_entry("burst_rd2",   MEM_READ,  16'h0042, 32'h0,         1'b0, STALL_NONE, 0);
    // Response back-pressure
    add_entry("bp_wr40",     MEM_WRITE, 16'h0040, 32'h0,         1'b1, STALL_RAND, 0);
    add_entry("bp_rd40",     MEM_READ,  16'h0040, 32'h0,         1'b0, STALL_LONG, 0);
    add_entry("bp_rd10",     MEM_READ,  16'h0010, 32'h0,         1'b0, STALL_RAND, 0);
    add_entry("bp_wr80",     MEM_WRITE, 16'h0080, 32'h0,         1'b1, STALL_LONG, 0);
    add_entry("bp_rd80",     MEM_READ,  16'h0080, 32'h0,         1'b0, STALL_RAND, 0);
    add_entry("bp_rd180",    MEM_READ,  16'h0180, 32'h0,         1'b0, STALL_RAND, 0);
    add_entry("bp_wr00",     MEM_WRITE, 16'h0000, 32'hFFFF_FFFF, 1'b0, STALL_RAND, 0);
    add_entry("bp_rd00",     MEM_READ,  16'h0000, 32'h0,         1'b0, STALL_LONG, 0);
    add_entry("bp_rd12",     MEM_READ,  16'h0012, 32'h0,         1'b0, STALL_RAND, 0);
    add_entry("tail_rd20",   MEM_READ,  16'h0020, 32'h0,         1'b0, STALL_NONE, 1);
  endtask

  // Drives one request, waits for acceptance and records the expected response
  task automatic issue_request(input int idx);
    mem_req_t req;
    mem_rsp_t exp;
    int       slot;
    req.op    = t_op[idx];
    req.addr  = t_addr[idx];
    req.wdata = t_rand[idx] ? $random(seed) : t_wdata[idx];
    @(posedge clk_i);
    req_i       <= req;
    req_valid_i <= 1'b1;
    @(negedge clk_i);
    while (!req_ready_o) @(negedge clk_i);
    // Transfer happens on the coming rising edge
    slot   = int'(req.addr) % `SLINK_MEM_WORDS;
    exp.op = req.op;
    if (req.op == MEM_WRITE) begin
      ref_mem[slot] = req.wdata;
      exp.rdata     = req.wdata;
    end else begin
      exp.rdata = ref_mem[slot];
    end
    exp_q.push_back(exp);
    idx_q.push_back(idx);
  endtask

  task automatic check_rsp_idle(input string when);
    assert (rsp_valid_o === 1'b0) else begin
      errors++;
      $display("[FAIL] %s: expected rsp_valid_o 0, got %b", when, rsp_valid_o);
    end
    checks++;
  endtask

  // Ready pattern for the response at the head of the queue
  function automatic logic choose_ready();
    int mode;
    if (idx_q.size() == 0) begin
      return 1'b1;
    end
    mode = t_stall[idx_q[0]];
    if (mode == STALL_RAND) begin
      return logic'($random(seed) & 1);
    end else if (mode == STALL_LONG) begin
      return stall_cnt >= LONG_STALL;
    end
    return 1'b1;
  endfunction

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    seed        = 75872;
    errors      = 0;
    checks      = 0;
    rst_i       = 1'b1;
    req_i       = '0;
    req_valid_i = 1'b0;
    rsp_ready_i = 1'b0;
    fill_table();

    repeat (RESET_CYCLES - 1) begin
      @(negedge clk_i);
      check_rsp_idle("reset");
    end
    @(posedge clk_i);
    rst_i <= 1'b0;

    // Link must come up on its own after reset
    @(negedge clk_i);
    check_rsp_idle("after_reset");
    for (int w = 0; w < 8 && !req_ready_o; w++) @(negedge clk_i);
    assert (req_ready_o === 1'b1) else begin
      errors++;
      $display("req_ready_o did not rise within 8 cycles after reset release");
    end

    for (int i = 0; i < n_entries; i++) begin
      repeat (t_gap[i]) begin
        @(posedge clk_i);
        req_valid_i <= 1'b0;
      end
      issue_request(i);
    end
    @(posedge clk_i);
    req_valid_i <= 1'b0;

    while (exp_q.size() != 0) @(negedge clk_i);
    // Quiet period to catch duplicated responses
    repeat (40) @(negedge clk_i);

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  //////////////////////////////
  // Response side
  //////////////////////////////

  initial begin : rsp_side
    mem_rsp_t held_rsp;
    mem_rsp_t exp;
    logic     held;
    int       head;
    held      = 1'b0;
    stall_cnt = 0;
    @(negedge rst_i);
    forever begin
      @(posedge clk_i);
      rsp_ready_i <= choose_ready();
      @(negedge clk_i);
      if (held) begin
        assert (rsp_valid_o) else begin
          errors++;
          $display("rsp_valid_o dropped before the response was taken");
        end
        if (rsp_valid_o && idx_q.size() != 0) begin
          assert (rsp_o === held_rsp) else begin
            errors++;
            $display("[FAIL] %s held: expected %h, got %h",
                     t_name[idx_q[0]], held_rsp, rsp_o);
          end
        end
      end
      if (rsp_valid_o && rsp_ready_i) begin
        held      = 1'b0;
        stall_cnt = 0;
        if (exp_q.size() == 0) begin
          errors++;
          $display("A response arrived with no request outstanding");
        end else begin
          exp  = exp_q.pop_front();
          head = idx_q.pop_front();
          assert (rsp_o === exp) else begin
            errors++;
            $display("[FAIL] %s: expected %h, got %h", t_name[head], exp, rsp_o);
          end
          checks++;
        end
      end else if (rsp_valid_o) begin
        held     = 1'b1;
        held_rsp = rsp_o;
        stall_cnt++;
      end
    end
  end

  // Watchdog
  initial begin
    #(TIMEOUT_NS);
    $display("Timeout: the link stopped making progress before all responses came back");
    $display("Errors found");
    $finish;
  end

endmodule

/* source/slink_top.sv */
// Serial memory link loop: host requests cross a lane link to a DRAM model,
// responses return over a second link. Single clock, single-rate lanes.
// At most three requests are in flight; responses keep request order.

`timescale 1ns/100ps

`include "slink_defs.svh"

module slink_top import slink_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_i,
  input  mem_req_t req_i,
  input  logic     req_valid_i,
  output logic     req_ready_o,
  output mem_rsp_t rsp_o,
  output logic     rsp_valid_o,
  input  logic     rsp_ready_i
);

  // Request lanes, host to memory side
  logic [`SLINK_NUM_LANES-1:0] req_lane_data;
  logic                        req_lane_valid;
  logic                        req_link_ready;

  // Response lanes, memory side back to host
  logic [`SLINK_NUM_LANES-1:0] rsp_lane_data;
  logic                        rsp_lane_valid;
  logic                        rsp_link_ready;

  // Memory-side word interfaces
  mem_req_t dram_req;
  logic     dram_req_valid;
  logic     dram_req_ready;
  mem_rsp_t dram_rsp;
  logic     dram_rsp_valid;
  logic     dram_rsp_ready;

  //////////////////////////////
  // Request link
  //////////////////////////////

  slink_serializer #(.WIDTH($bits(mem_req_t))) u_req_ser (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .data_i       (req_i),
    .valid_i      (req_valid_i),
    .ready_o      (req_ready_o),
    .lane_data_o  (req_lane_data),
    .lane_valid_o (req_lane_valid),
    .link_ready_i (req_link_ready)
  );

  slink_deserializer #(.WIDTH($bits(mem_req_t))) u_req_des (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .lane_data_i  (req_lane_data),
    .lane_valid_i (req_lane_valid),
    .link_ready_o (req_link_ready),
    .data_o       (dram_req),
    .valid_o      (dram_req_valid),
    .ready_i      (dram_req_ready)
  );

  //////////////////////////////
  // Far-side memory
  //////////////////////////////

  slink_dram_model u_dram (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .req_i       (dram_req),
    .req_valid_i (dram_req_valid),
    .req_ready_o (dram_req_ready),
    .rsp_o       (dram_rsp),
    .rsp_valid_o (dram_rsp_valid),
    .rsp_ready_i (dram_rsp_ready)
  );

  //////////////////////////////
  // Response link
  //////////////////////////////

  slink_serializer #(.WIDTH($bits(mem_rsp_t))) u_rsp_ser (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .data_i       (dram_rsp),
    .valid_i      (dram_rsp_valid),
    .ready_o      (dram_rsp_ready),
    .lane_data_o  (rsp_lane_data),
    .lane_valid_o (rsp_lane_valid),
    .link_ready_i (rsp_link_ready)
  );

  slink_deserializer #(.WIDTH($bits(mem_rsp_t))) u_rsp_des (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .lane_data_i  (rsp_lane_data),
    .lane_valid_i (rsp_lane_valid),
    .link_ready_o (rsp_link_ready),
    .data_o       (rsp_o),
    .valid_o      (rsp_valid_o),
    .ready_i      (rsp_ready_i)
  );

endmodule

/* source/slink_dram_model.sv */
// Far-side word memory, one request at a time, response held until taken.
// Only the low address bits index the array, so addresses alias by the depth.
// Memory contents are not initialised; read before write returns X.

`timescale 1ns/100ps

`include "slink_defs.svh"

module slink_dram_model import slink_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_i,
  input  mem_req_t req_i,
  input  logic     req_valid_i,
  output logic     req_ready_o,
  output mem_rsp_t rsp_o,
  output logic     rsp_valid_o,
  input  logic     rsp_ready_i
);

  localparam int IDX_W = $clog2(`SLINK_MEM_WORDS);

  logic [`SLINK_DATA_W-1:0] mem_q [`SLINK_MEM_WORDS];
  logic [IDX_W-1:0]         idx;
  logic                     accept;
  mem_rsp_t                 rsp_q;
  logic                     rsp_valid_q;

  assign idx         = req_i.addr[IDX_W-1:0];
  // Busy while a response waits
  assign req_ready_o = !rsp_valid_q;
  assign accept      = req_valid_i && req_ready_o;

  //////////////////////////////
  // Array and response data
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    if (accept) begin
      rsp_q.op <= req_i.op;
      if (req_i.op == MEM_WRITE) begin
        mem_q[idx]  <= req_i.wdata;
        rsp_q.rdata <= req_i.wdata;
      end else begin
        rsp_q.rdata <= mem_q[idx];
      end
    end
  end

  // Response valid one cycle after acceptance
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rsp_valid_q <= 1'b0;
    end else if (accept) begin
      rsp_valid_q <= 1'b1;
    end else if (rsp_ready_i) begin
      rsp_valid_q <= 1'b0;
    end
  end

  assign rsp_o       = rsp_q;
  assign rsp_valid_o = rsp_valid_q;

  // Held response must not change until the link takes it
  a_rsp_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    (rsp_valid_o && !rsp_ready_i) |=> (rsp_valid_o && $stable(rsp_o)))
    else $error("DRAM response changed while held");

endmodule

/* source/slink_deserializer.sv */
// Lane-beat to word deserializer with a single holding register.
// link_ready_o is high exactly while the holding register is empty.
// The sender must not start a frame while link_ready_o is low.

`timescale 1ns/100ps

`include "slink_defs.svh"

module slink_deserializer #(
  parameter int WIDTH = 49
) (
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  logic [`SLINK_NUM_LANES-1:0] lane_data_i,
  input  logic                        lane_valid_i,
  output logic                        link_ready_o,
  output logic [WIDTH-1:0]            data_o,
  output logic                        valid_o,
  input  logic                        ready_i
);

  localparam int LANES = `SLINK_NUM_LANES;
  localparam int BEATS = (WIDTH + LANES - 1) / LANES;
  localparam int PAD_W = BEATS * LANES;
  localparam int CNT_W = $clog2(BEATS + 1);

  logic [CNT_W-1:0] beat_cnt_q;
  logic [PAD_W-1:0] asm_q;
  logic [PAD_W-1:0] asm_next;
  logic [WIDTH-1:0] hold_q;
  logic             valid_q;
  logic             last_beat;

  //////////////////////////////
  // Assembly
  //////////////////////////////

  // New beats enter at the top, so the first beat ends up at bit 0
  assign asm_next  = {lane_data_i, asm_q[PAD_W-1:LANES]};
  assign last_beat = lane_valid_i && (beat_cnt_q == CNT_W'(BEATS - 1));

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      beat_cnt_q <= '0;
    end else if (last_beat) begin
      beat_cnt_q <= '0;
    end else if (lane_valid_i) begin
      beat_cnt_q <= beat_cnt_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (lane_valid_i) begin
      asm_q <= asm_next;
    end
  end

  //////////////////////////////
  // Holding register
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    if (last_beat) begin
      hold_q <= asm_next[WIDTH-1:0];
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_q <= 1'b0;
    end else if (last_beat) begin
      valid_q <= 1'b1;
    end else if (ready_i) begin
      valid_q <= 1'b0;
    end
  end

  assign data_o       = hold_q;
  assign valid_o      = valid_q;
  assign link_ready_o = !valid_q;

  // Relies on the serializer honouring link_ready
  a_no_overrun: assert property (@(posedge clk_i) disable iff (rst_i)
    lane_valid_i |-> !valid_q)
    else $error("deserializer got a beat while its holding register was full");

endmodule

/* source/slink_serializer.sv */
// Word to lane-beat serializer for single-rate lanes with one frame at a time.
// A frame starts only while link_ready_i is high and then runs without gaps.
// Beats go out least significant lanes first; the word is zero-padded to whole beats.

`timescale 1ns/100ps

`include "slink_defs.svh"

module slink_serializer import slink_pkg::*; #(
  parameter int WIDTH = 49
) (
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  logic [WIDTH-1:0]            data_i,
  input  logic                        valid_i,
  output logic                        ready_o,
  output logic [`SLINK_NUM_LANES-1:0] lane_data_o,
  output logic                        lane_valid_o,
  input  logic                        link_ready_i
);

  localparam int LANES = `SLINK_NUM_LANES;
  // Beats per frame rounded up
  localparam int BEATS = (WIDTH + LANES - 1) / LANES;
  localparam int PAD_W = BEATS * LANES;
  localparam int CNT_W = $clog2(BEATS + 1);

  ser_state_e       state_q;
  logic [CNT_W-1:0] beat_cnt_q;
  logic [PAD_W-1:0] shift_q;
  logic             accept;
  logic             last_beat;

  //////////////////////////////
  // Handshake
  //////////////////////////////

  assign ready_o   = (state_q == SER_IDLE) && link_ready_i;
  assign accept    = valid_i && ready_o;
  assign last_beat = (beat_cnt_q == CNT_W'(BEATS - 1));

  //////////////////////////////
  // Frame FSM
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q    <= SER_IDLE;
      beat_cnt_q <= '0;
    end else begin
      case (state_q)
        SER_IDLE: begin
          if (accept) begin
            state_q    <= SER_SEND;
            beat_cnt_q <= '0;
          end
        end
        SER_SEND: begin
          beat_cnt_q <= beat_cnt_q + 1'b1;
          if (last_beat) begin
            state_q <= SER_IDLE;
          end
        end
        default: state_q <= SER_IDLE;
      endcase
    end
  end

  // Low lanes leave the payload shifter first
  always_ff @(posedge clk_i) begin
    if (accept) begin
      shift_q <= PAD_W'(data_i);
    end else if (state_q == SER_SEND) begin
      shift_q <= shift_q >> LANES;
    end
  end

  assign lane_data_o  = shift_q[LANES-1:0];
  assign lane_valid_o = (state_q == SER_SEND);

  //////////////////////////////
  // Checks
  //////////////////////////////

  // Accepted word gives exactly BEATS back-to-back beats
  a_frame_len: assert property (@(posedge clk_i) disable iff (rst_i)
    accept |=> lane_valid_o [*BEATS] ##1 !lane_valid_o)
    else $error("serializer frame length differs from %0d beats", BEATS);

  // First beat on the lanes only after the far side was ready
  a_no_start_busy: assert property (@(posedge clk_i) disable iff (rst_i)
    $rose(lane_valid_o) |-> $past(link_ready_i))
    else $error("serializer started a frame while link_ready was low");

endmodule

/* source/slink_pkg.sv */
// Types for the serial memory link.
// Struct widths follow the sizes in slink_defs.svh: request 49 bits, response 33 bits.

`include "slink_defs.svh"

package slink_pkg;

  //////////////////////////////
  // Memory operations
  //////////////////////////////

  typedef enum logic {
    MEM_READ  = 1'b0,
    MEM_WRITE = 1'b1
  } mem_op_e;

  // Host request, op sits in the top bit
  typedef struct packed {
    mem_op_e                   op;
    logic [`SLINK_ADDR_W-1:0]  addr;
    logic [`SLINK_DATA_W-1:0]  wdata;
  } mem_req_t;

  // Writes echo the stored word in rdata
  typedef struct packed {
    mem_op_e                   op;
    logic [`SLINK_DATA_W-1:0]  rdata;
  } mem_rsp_t;

  //////////////////////////////
  // Serializer FSM
  //////////////////////////////

  typedef enum logic {
    SER_IDLE = 1'b0,
    SER_SEND = 1'b1
  } ser_state_e;

endpackage

/* include/slink_defs.svh */
// Link and memory sizing shared by the package and the RTL.
// Lane count must divide into whole beats; words are padded up to a lane multiple.
// Only log2(SLINK_MEM_WORDS) address bits reach the memory, so higher bits alias.

`ifndef SLINK_DEFS_SVH
`define SLINK_DEFS_SVH

// Data lanes per direction
`define SLINK_NUM_LANES 4

// Request address and data word widths in bits
`define SLINK_ADDR_W 16
`define SLINK_DATA_W 32

// DRAM model depth in words
`define SLINK_MEM_WORDS 256

`endif
